// File: design/osc_pkg.sv
package osc_pkg;

  ////////////////////////////////////////
  // Waveform select
  ////////////////////////////////////////

  // Codes as seen in the select register
  typedef enum logic [1:0] {
    osc_square_e   = 2'd0,
    osc_triangle_e = 2'd1,
    osc_saw_e      = 2'd2,
    // Reserved, core outputs zero
    osc_sine_e     = 2'd3
  } osc_waveform_t;

  ////////////////////////////////////////
  // Register map
  ////////////////////////////////////////

  // Byte offsets on the 4-bit address
  localparam logic [3:0] osc_reg_select_c    = 4'h0;
  localparam logic [3:0] osc_reg_frequency_c = 4'h4;
  localparam logic [3:0] osc_reg_duty_c      = 4'h8;
  // Read only, current waveform sample
  localparam logic [3:0] osc_reg_wave_c      = 4'hC;

  ////////////////////////////////////////
  // AXI4-Lite
  ////////////////////////////////////////

  // Bus data width
  localparam int axi_data_width_c = 32;

  // Response codes
  localparam logic [1:0] axi_resp_okay_c   = 2'b00;
  localparam logic [1:0] axi_resp_slverr_c = 2'b10;

endpackage

// File: design/osc_axi_regs.sv
`timescale 1ns/1ns

module osc_axi_regs import osc_pkg::*; #(
  parameter int counter_width = 16,
  parameter int wave_width    = 8
) (
  input  logic                        clk,
  input  logic                        rst_n,

  // Write address and data
  input  logic [3:0]                  s_axi_awaddr,
  input  logic                        s_axi_awvalid,
  output logic                        s_axi_awready,
  input  logic [axi_data_width_c-1:0] s_axi_wdata,
  input  logic                        s_axi_wvalid,
  output logic                        s_axi_wready,

  // Write response
  output logic [1:0]                  s_axi_bresp,
  output logic                        s_axi_bvalid,
  input  logic                        s_axi_bready,

  // Read address
  input  logic [3:0]                  s_axi_araddr,
  input  logic                        s_axi_arvalid,
  output logic                        s_axi_arready,

  // Read data
  output logic [axi_data_width_c-1:0] s_axi_rdata,
  output logic [1:0]                  s_axi_rresp,
  output logic                        s_axi_rvalid,
  input  logic                        s_axi_rready,

  // Current sample for read-back
  input  logic [wave_width-1:0]       waveform,

  // Configuration to the core
  output osc_waveform_t               cr_waveform_select,
  output logic [counter_width-1:0]    cr_frequency,
  output logic [counter_width-1:0]    cr_duty_cycle
);

  logic                        wr_hs;
  logic                        wr_addr_ok;
  logic                        rd_hs;
  logic [axi_data_width_c-1:0] rd_data;
  logic [1:0]                  rd_resp;

  ////////////////////////////////////////
  // Write channel
  ////////////////////////////////////////

  // Address and data taken together, only with no response pending
  assign wr_hs         = s_axi_awvalid && s_axi_wvalid && !s_axi_bvalid;
  assign s_axi_awready = wr_hs;
  assign s_axi_wready  = wr_hs;

  // Writable offsets only, wave register is read only
  assign wr_addr_ok = (s_axi_awaddr == osc_reg_select_c)    ||
                      (s_axi_awaddr == osc_reg_frequency_c) ||
                      (s_axi_awaddr == osc_reg_duty_c);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cr_waveform_select <= osc_square_e;
      cr_frequency       <= '0;
      cr_duty_cycle      <= '0;
      s_axi_bvalid       <= 1'b0;
    end else begin
      if (wr_hs) begin
        s_axi_bvalid <= 1'b1;
        // Whole register replaced, upper bits dropped
        case (s_axi_awaddr)
          osc_reg_select_c: begin
            cr_waveform_select <= osc_waveform_t'(s_axi_wdata[1:0]);
          end
          osc_reg_frequency_c: begin
            cr_frequency <= s_axi_wdata[counter_width-1:0];
          end
          osc_reg_duty_c: begin
            cr_duty_cycle <= s_axi_wdata[counter_width-1:0];
          end
          default: begin
            // Bad offset, registers untouched
          end
        endcase
      end else if (s_axi_bready) begin
        s_axi_bvalid <= 1'b0;
      end
    end
  end

  // Response code, held while bvalid waits on bready
  always_ff @(posedge clk) begin
    if (wr_hs) begin
      s_axi_bresp <= wr_addr_ok ? axi_resp_okay_c : axi_resp_slverr_c;
    end
  end

  ////////////////////////////////////////
  // Read channel
  ////////////////////////////////////////

  // New address only once the last response is gone
  assign s_axi_arready = !s_axi_rvalid;
  assign rd_hs         = s_axi_arvalid && s_axi_arready;

  // Read decode, values zero extended to bus width
  always_comb begin
    rd_data = '0;
    rd_resp = axi_resp_okay_c;
    case (s_axi_araddr)
      osc_reg_select_c: begin
        rd_data[1:0] = cr_waveform_select;
      end
      osc_reg_frequency_c: begin
        rd_data[counter_width-1:0] = cr_frequency;
      end
      osc_reg_duty_c: begin
        rd_data[counter_width-1:0] = cr_duty_cycle;
      end
      osc_reg_wave_c: begin
        rd_data[wave_width-1:0] = waveform;
      end
      default: begin
        rd_resp = axi_resp_slverr_c;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s_axi_rvalid <= 1'b0;
    end else if (rd_hs) begin
      s_axi_rvalid <= 1'b1;
    end else if (s_axi_rready) begin
      s_axi_rvalid <= 1'b0;
    end
  end

  // Data and code captured at the handshake
  always_ff @(posedge clk) begin
    if (rd_hs) begin
      s_axi_rdata <= rd_data;
      s_axi_rresp <= rd_resp;
    end
  end

endmodule

// File: design/osc_square.sv
`timescale 1ns/1ns

module osc_square #(
  parameter int wave_width    = 8,
  parameter int counter_width = 16
) (
  input  logic                     clk,
  input  logic                     rst_n,

  // Period end and high time, in clocks
  input  logic [counter_width-1:0] cr_frequency,
  input  logic [counter_width-1:0] cr_duty_cycle,

  output logic [wave_width-1:0]    wave_square
);

  logic [counter_width-1:0] period_cnt;
  logic                     period_end;

  ////////////////////////////////////////
  // Period counter
  ////////////////////////////////////////

  // Greater-or-equal so a lowered limit never overruns
  assign period_end = (period_cnt >= cr_frequency);

  // Wraps after frequency+1 clocks
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      period_cnt <= '0;
    end else if (period_end) begin
      period_cnt <= '0;
    end else begin
      period_cnt <= period_cnt + 1'b1;
    end
  end

  ////////////////////////////////////////
  // Duty compare
  ////////////////////////////////////////

  // Full scale for the first duty clocks of the period
  // Duty 0 stays low, duty past the limit stays high
  assign wave_square = (period_cnt < cr_duty_cycle) ? '1 : '0;

endmodule

// File: design/osc_ramp.sv
`timescale 1ns/1ns

module osc_ramp #(
  parameter int wave_width = 8,
  parameter int tick_clks  = 4
) (
  input  logic                  clk,
  input  logic                  rst_n,

  // Both waves from the same ramp, same phase
  output logic [wave_width-1:0] wave_saw,
  output logic [wave_width-1:0] wave_triangle
);

  // At least one bit even for a tick every clock
  localparam int tick_w = (tick_clks > 1) ? $clog2(tick_clks) : 1;
  localparam logic [tick_w-1:0] tick_last_c = tick_w'(tick_clks - 1);

  logic [tick_w-1:0]     tick_cnt;
  logic                  tick;
  logic [wave_width-1:0] ramp;
  logic [wave_width-1:0] ramp_shl;

  ////////////////////////////////////////
  // Step tick
  ////////////////////////////////////////

  assign tick = (tick_cnt == tick_last_c);

  // Free running 0 .. tick_clks-1
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tick_cnt <= '0;
    end else if (tick) begin
      tick_cnt <= '0;
    end else begin
      tick_cnt <= tick_cnt + 1'b1;
    end
  end

  ////////////////////////////////////////
  // Ramp
  ////////////////////////////////////////

  // One step per tick, natural wrap at full scale
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ramp <= '0;
    end else if (tick) begin
      ramp <= ramp + 1'b1;
    end
  end

  assign wave_saw = ramp;

  // Double the slope, top bit dropped
  assign ramp_shl = {ramp[wave_width-2:0], 1'b0};

  // Rising half as is, falling half mirrored
  assign wave_triangle = ramp[wave_width-1] ? ~ramp_shl : ramp_shl;

endmodule

// File: design/oscillator_core.sv
`timescale 1ns/1ns

module oscillator_core import osc_pkg::*; #(
  parameter int wave_width    = 8,
  parameter int counter_width = 16,
  parameter int tick_clks     = 4
) (
  input  logic                     clk,
  input  logic                     rst_n,

  // Configuration registers
  input  osc_waveform_t            cr_waveform_select,
  input  logic [counter_width-1:0] cr_frequency,
  input  logic [counter_width-1:0] cr_duty_cycle,

  output logic [wave_width-1:0]    waveform
);

  logic [wave_width-1:0] wave_square;
  logic [wave_width-1:0] wave_saw;
  logic [wave_width-1:0] wave_triangle;
  logic [wave_width-1:0] wave_sel;

  ////////////////////////////////////////
  // Generators
  ////////////////////////////////////////

  // Both run all the time, only the mux picks
  osc_square #(
    .wave_width    (wave_width),
    .counter_width (counter_width)
  ) i_square (
    .clk           (clk),
    .rst_n         (rst_n),
    .cr_frequency  (cr_frequency),
    .cr_duty_cycle (cr_duty_cycle),
    .wave_square   (wave_square)
  );

  osc_ramp #(
    .wave_width    (wave_width),
    .tick_clks     (tick_clks)
  ) i_ramp (
    .clk           (clk),
    .rst_n         (rst_n),
    .wave_saw      (wave_saw),
    .wave_triangle (wave_triangle)
  );

  ////////////////////////////////////////
  // Output select
  ////////////////////////////////////////

  // Sine code reserved, gives zero
  always_comb begin
    case (cr_waveform_select)
      osc_square_e:   wave_sel = wave_square;
      osc_triangle_e: wave_sel = wave_triangle;
      osc_saw_e:      wave_sel = wave_saw;
      default:        wave_sel = '0;
    endcase
  end

  // One clock latency, select and sample from the same cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      waveform <= '0;
    end else begin
      waveform <= wave_sel;
    end
  end

endmodule

// File: design/osc_top.sv
`timescale 1ns/1ns

module osc_top import osc_pkg::*; #(
  parameter int wave_width    = 8,
  parameter int counter_width = 16,
  parameter int tick_clks     = 4
) (
  input  logic                        clk,
  input  logic                        rst_n,

  // AXI4-Lite slave
  input  logic [3:0]                  s_axi_awaddr,
  input  logic                        s_axi_awvalid,
  output logic                        s_axi_awready,
  input  logic [axi_data_width_c-1:0] s_axi_wdata,
  input  logic                        s_axi_wvalid,
  output logic                        s_axi_wready,
  output logic [1:0]                  s_axi_bresp,
  output logic                        s_axi_bvalid,
  input  logic                        s_axi_bready,
  input  logic [3:0]                  s_axi_araddr,
  input  logic                        s_axi_arvalid,
  output logic                        s_axi_arready,
  output logic [axi_data_width_c-1:0] s_axi_rdata,
  output logic [1:0]                  s_axi_rresp,
  output logic                        s_axi_rvalid,
  input  logic                        s_axi_rready,

  // Generated wave
  output logic [wave_width-1:0]       waveform
);

  // Register block to core
  osc_waveform_t            cr_waveform_select;
  logic [counter_width-1:0] cr_frequency;
  logic [counter_width-1:0] cr_duty_cycle;

  ////////////////////////////////////////
  // Register block
  ////////////////////////////////////////

  osc_axi_regs #(
    .counter_width (counter_width),
    .wave_width    (wave_width)
  ) i_regs (
    .clk, .rst_n,
    .s_axi_awaddr, .s_axi_awvalid, .s_axi_awready,
    .s_axi_wdata, .s_axi_wvalid, .s_axi_wready,
    .s_axi_bresp, .s_axi_bvalid, .s_axi_bready,
    .s_axi_araddr, .s_axi_arvalid, .s_axi_arready,
    .s_axi_rdata, .s_axi_rresp, .s_axi_rvalid, .s_axi_rready,
    // Read-back of the live output
    .waveform,
    .cr_waveform_select, .cr_frequency, .cr_duty_cycle
  );

  ////////////////////////////////////////
  // Oscillator
  ////////////////////////////////////////

  oscillator_core #(
    .wave_width    (wave_width),
    .counter_width (counter_width),
    .tick_clks     (tick_clks)
  ) i_core (
    .clk, .rst_n,
    .cr_waveform_select, .cr_frequency, .cr_duty_cycle,
    .waveform
  );

endmodule

// File: sim/osc_clock_gen.sv
`timescale 1ns/1ns

module osc_clock_gen #(
  parameter int period_ns    = 100,
  parameter int reset_cycles = 10,
  parameter int release_ns   = 10
) (
  output logic clk,
  output logic rst_n
);

  // Free running clock, first edge rising
  initial begin
    clk = 1'b0;
    forever begin
      #(period_ns / 2) clk = ~clk;
    end
  end

  // Reset released just after a rising edge
  initial begin
    rst_n = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    #release_ns rst_n = 1'b1;
  end

endmodule

// File: sim/osc_tb.sv
`timescale 1ns/1ns

module osc_tb import osc_pkg::*; ();

  localparam int wave_width    = 8;
  localparam int counter_width = 16;
  localparam int tick_clks     = 4;
  localparam int drive_delay   = 10;
  localparam int timeout_clks  = 50;
  localparam int random_ops    = 200;
  // Clocks for one full ramp cycle
  localparam int ramp_wrap     = (1 << wave_width) * tick_clks;

  logic                        clk;
  logic                        rst_n;
  logic [3:0]                  s_axi_awaddr;
  logic                        s_axi_awvalid;
  logic                        s_axi_awready;
  logic [axi_data_width_c-1:0] s_axi_wdata;
  logic                        s_axi_wvalid;
  logic                        s_axi_wready;
  logic [1:0]                  s_axi_bresp;
  logic                        s_axi_bvalid;
  logic                        s_axi_bready;
  logic [3:0]                  s_axi_araddr;
  logic                        s_axi_arvalid;
  logic                        s_axi_arready;
  logic [axi_data_width_c-1:0] s_axi_rdata;
  logic [1:0]                  s_axi_rresp;
  logic                        s_axi_rvalid;
  logic                        s_axi_rready;
  logic [wave_width-1:0]       waveform;

  int seed;

  // Model state
  osc_waveform_t               m_sel;
  logic [counter_width-1:0]    m_freq;
  logic [counter_width-1:0]    m_duty;
  logic [counter_width-1:0]    m_period;
  int                          m_tick;
  logic [wave_width-1:0]       m_ramp;
  logic [wave_width-1:0]       m_wave;
  logic                        m_bvalid;
  logic                        m_rvalid;
  logic [1:0]                  m_bresp;
  logic [1:0]                  m_rresp;
  logic [axi_data_width_c-1:0] m_rdata;

  osc_clock_gen #(.period_ns(100), .reset_cycles(10), .release_ns(drive_delay)) i_clk_gen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  osc_top #(
    .wave_width    (wave_width),
    .counter_width (counter_width),
    .tick_clks     (tick_clks)
  ) i_dut (
    .clk, .rst_n,
    .s_axi_awaddr, .s_axi_awvalid, .s_axi_awready,
    .s_axi_wdata, .s_axi_wvalid, .s_axi_wready,
    .s_axi_bresp, .s_axi_bvalid, .s_axi_bready,
    .s_axi_araddr, .s_axi_arvalid, .s_axi_arready,
    .s_axi_rdata, .s_axi_rresp, .s_axi_rvalid, .s_axi_rready,
    .waveform
  );

  ////////////////////////////////////////
  // Reporting and compares
  ////////////////////////////////////////

  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("Finished with errors");
    $fatal(1);
  endtask

  task automatic check_wave(input string name, input logic [wave_width-1:0] act,
                            input logic [wave_width-1:0] exp);
    if (act !== exp) begin
      stop_on_error($sformatf("CHECK FAILED %s expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic check_select(input string name, input osc_waveform_t act,
                              input osc_waveform_t exp);
    if (act !== exp) begin
      stop_on_error($sformatf("CHECK FAILED %s expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic check_resp(input string name, input logic [1:0] act, input logic [1:0] exp);
    if (act !== exp) begin
      stop_on_error($sformatf("CHECK FAILED %s expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic check_data(input string name, input logic [axi_data_width_c-1:0] act,
                            input logic [axi_data_width_c-1:0] exp);
    if (act !== exp) begin
      stop_on_error($sformatf("CHECK FAILED %s expected %h actual %h", name, exp, act));
    end
  endtask

  // Handshake flags
  task automatic check_flag(input string name, input logic act, input logic exp);
    if (act !== exp) begin
      stop_on_error($sformatf("CHECK FAILED %s expected %h actual %h", name, exp, act));
    end
  endtask

  function automatic logic [31:0] next_random();
    next_random = $random(seed);
  endfunction

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  // Generator value picked by the current select
  function automatic logic [wave_width-1:0] model_pick();
    logic [wave_width-1:0] folded;
    folded = m_ramp << 1;
    // Second half of the ramp runs back down
    if (m_ramp[wave_width-1]) begin
      folded = ~folded;
    end
    case (m_sel)
      osc_square_e:   model_pick = (m_period < m_duty) ? {wave_width{1'b1}} : '0;
      osc_triangle_e: model_pick = folded;
      osc_saw_e:      model_pick = m_ramp;
      default:        model_pick = '0;
    endcase
  endfunction

  always @(posedge clk) begin
    if (!rst_n) begin
      m_sel    <= osc_square_e;
      m_freq   <= '0;
      m_duty   <= '0;
      m_period <= '0;
      m_tick   <= 0;
      m_ramp   <= '0;
      m_wave   <= '0;
      m_bvalid <= 1'b0;
      m_rvalid <= 1'b0;
      m_bresp  <= axi_resp_okay_c;
      m_rresp  <= axi_resp_okay_c;
      m_rdata  <= '0;
    end else begin
      // Output register, one clock behind the generators
      m_wave <= model_pick();
      // Period of frequency+1 clocks
      if (m_period >= m_freq) begin
        m_period <= '0;
      end else begin
        m_period <= m_period + 1'b1;
      end
      // Ramp step every tick_clks clocks
      if (m_tick == tick_clks - 1) begin
        m_tick <= 0;
        m_ramp <= m_ramp + 1'b1;
      end else begin
        m_tick <= m_tick + 1;
      end
      // Write handshake and response
      if (s_axi_awvalid && s_axi_wvalid && !m_bvalid) begin
        m_bvalid <= 1'b1;
        m_bresp  <= axi_resp_okay_c;
        case (s_axi_awaddr)
          osc_reg_select_c:    m_sel  <= osc_waveform_t'(s_axi_wdata[1:0]);
          osc_reg_frequency_c: m_freq <= s_axi_wdata[counter_width-1:0];
          osc_reg_duty_c:      m_duty <= s_axi_wdata[counter_width-1:0];
          default:             m_bresp <= axi_resp_slverr_c;
        endcase
      end else if (s_axi_bready) begin
        m_bvalid <= 1'b0;
      end
      // Read handshake, values before this edge
      if (s_axi_arvalid && !m_rvalid) begin
        m_rvalid <= 1'b1;
        m_rresp  <= axi_resp_okay_c;
        case (s_axi_araddr)
          osc_reg_select_c:    m_rdata <= 32'(m_sel);
          osc_reg_frequency_c: m_rdata <= 32'(m_freq);
          osc_reg_duty_c:      m_rdata <= 32'(m_duty);
          osc_reg_wave_c:      m_rdata <= 32'(m_wave);
          default: begin
            m_rdata <= '0;
            m_rresp <= axi_resp_slverr_c;
          end
        endcase
      end else if (s_axi_rready) begin
        m_rvalid <= 1'b0;
      end
    end
  end

  // Mid-cycle compares from the first model reset edge on
  initial begin
    @(posedge clk);
    forever begin
      @(negedge clk);
      check_wave("waveform", waveform, m_wave);
      check_select("cr_waveform_select", i_dut.cr_waveform_select, m_sel);
      check_flag("s_axi_bvalid", s_axi_bvalid, m_bvalid);
      check_flag("s_axi_rvalid", s_axi_rvalid, m_rvalid);
      // Ready only with both channels valid and no response pending
      check_flag("s_axi_awready", s_axi_awready,
                 s_axi_awvalid && s_axi_wvalid && !m_bvalid);
      check_flag("s_axi_wready", s_axi_wready,
                 s_axi_awvalid && s_axi_wvalid && !m_bvalid);
      check_flag("s_axi_arready", s_axi_arready, !m_rvalid);
    end
  end

  ////////////////////////////////////////
  // Bus tasks
  ////////////////////////////////////////

  // Entered and left just after a rising edge
  task automatic idle(input int cycles);
    repeat (cycles) begin
      @(posedge clk);
      #drive_delay;
    end
  endtask

  task automatic axi_write(input logic [3:0] addr, input logic [31:0] data);
    int   waited;
    logic done;
    s_axi_awaddr  = addr;
    s_axi_wdata   = data;
    s_axi_awvalid = 1'b1;
    s_axi_wvalid  = 1'b1;
    waited = 0;
    @(negedge clk);
    while (!(s_axi_awready && s_axi_wready)) begin
      waited++;
      if (waited > timeout_clks) begin
        stop_on_error("Timeout: write address and data never accepted");
      end
      @(negedge clk);
    end
    @(posedge clk);
    #drive_delay;
    s_axi_awvalid = 1'b0;
    s_axi_wvalid  = 1'b0;
    // Response with random stalls
    waited = 0;
    done   = 1'b0;
    while (!done) begin
      s_axi_bready = (next_random() & 32'd3) != 0;
      @(negedge clk);
      if (s_axi_bvalid && s_axi_bready) begin
        check_resp("s_axi_bresp", s_axi_bresp, m_bresp);
        done = 1'b1;
      end else begin
        waited++;
        if (waited > timeout_clks) begin
          stop_on_error("Timeout: write response never completed");
        end
      end
      @(posedge clk);
      #drive_delay;
    end
    s_axi_bready = 1'b0;
  endtask

  task automatic axi_read(input logic [3:0] addr, output logic [31:0] data,
                          output logic [1:0] resp);
    int   waited;
    logic done;
    s_axi_araddr  = addr;
    s_axi_arvalid = 1'b1;
    waited = 0;
    @(negedge clk);
    while (!s_axi_arready) begin
      waited++;
      if (waited > timeout_clks) begin
        stop_on_error("Timeout: read address never accepted");
      end
      @(negedge clk);
    end
    @(posedge clk);
    #drive_delay;
    s_axi_arvalid = 1'b0;
    waited = 0;
    done   = 1'b0;
    while (!done) begin
      s_axi_rready = (next_random() & 32'd3) != 0;
      @(negedge clk);
      if (s_axi_rvalid && s_axi_rready) begin
        check_data("s_axi_rdata", s_axi_rdata, m_rdata);
        check_resp("s_axi_rresp", s_axi_rresp, m_rresp);
        data = s_axi_rdata;
        resp = s_axi_rresp;
        done = 1'b1;
      end else begin
        waited++;
        if (waited > timeout_clks) begin
          stop_on_error("Timeout: read data never completed");
        end
      end
      @(posedge clk);
      #drive_delay;
    end
    s_axi_rready = 1'b0;
  endtask

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  initial begin
    int                       i;
    int                       waited;
    logic [31:0]              rnd;
    logic [31:0]              rd_data;
    logic [1:0]               rd_resp;
    logic [counter_width-1:0] freq;
    logic [counter_width-1:0] duty;
    logic [3:0]               addr;
    seed          = 32'h10f7_a602;
    s_axi_awaddr  = '0;
    s_axi_awvalid = 1'b0;
    s_axi_wdata   = '0;
    s_axi_wvalid  = 1'b0;
    s_axi_bready  = 1'b0;
    s_axi_araddr  = '0;
    s_axi_arvalid = 1'b0;
    s_axi_rready  = 1'b0;

    waited = 0;
    @(negedge clk);
    while (rst_n !== 1'b1) begin
      waited++;
      if (waited > timeout_clks) begin
        stop_on_error("Timeout: reset never released");
      end
      @(negedge clk);
    end
    @(posedge clk);
    #drive_delay;

    // Configuration registers cleared by reset
    for (i = 0; i < 3; i++) begin
      axi_read(4'(i * 4), rd_data, rd_resp);
      check_data("s_axi_rdata", rd_data, '0);
      check_resp("s_axi_rresp", rd_resp, axi_resp_okay_c);
    end

    // Square, with duty 0 and duty above the period
    for (i = 0; i < 4; i++) begin
      rnd  = next_random();
      freq = counter_width'(rnd[4:0]) + 2;
      case (i)
        0:       duty = '0;
        1:       duty = freq + counter_width'(rnd[7:5]) + 1;
        default: duty = counter_width'(rnd[15:8]) % (freq + 1);
      endcase
      axi_write(osc_reg_frequency_c, {rnd[31:16], freq});
      axi_write(osc_reg_duty_c, {rnd[15:0], duty});
      axi_write(osc_reg_select_c, 32'(osc_square_e));
      idle(4 * (int'(freq) + 1) + 8);
    end

    // Triangle then sawtooth, each over a full ramp wrap
    axi_write(osc_reg_select_c, 32'(osc_triangle_e));
    idle(ramp_wrap + 16);
    axi_write(osc_reg_select_c, 32'(osc_saw_e));
    idle(ramp_wrap + 16);

    // Reserved code, then back to a live wave
    axi_write(osc_reg_select_c, 32'(osc_sine_e));
    idle(20);
    check_wave("waveform", waveform, '0);
    axi_write(osc_reg_select_c, 32'(osc_triangle_e));
    idle(30);

    // Random register map traffic
    for (i = 0; i < random_ops; i++) begin
      rnd  = next_random();
      addr = rnd[2] ? rnd[7:4] : {rnd[1:0], 2'b00};
      if (rnd[3]) begin
        axi_write(addr, next_random());
      end else begin
        axi_read(addr, rd_data, rd_resp);
      end
      idle(int'(rnd[10:8]));
    end

    $display("Finished with no errors");
    $finish;
  end

endmodule

// File: wave_osc.f
design/osc_pkg.sv
design/osc_axi_regs.sv
design/osc_square.sv
design/osc_ramp.sv
design/oscillator_core.sv
design/osc_top.sv
sim/osc_clock_gen.sv
sim/osc_tb.sv

// File: Bender.yml
package:
  name: wave_osc

dependencies: {}

sources:
  # Package first, then leaf modules up to the top level
  - files:
      - design/osc_pkg.sv
      - design/osc_axi_regs.sv
      - design/osc_square.sv
      - design/osc_ramp.sv
      - design/oscillator_core.sv
      - design/osc_top.sv

  # Testbench, top module osc_tb
  - target: simulation
    files:
      - sim/osc_clock_gen.sv
      - sim/osc_tb.sv

export_include_dirs: []

frozen: false

workspace: {}
